/* rtl/ReplayQueue_consts.svh */
/*
 * Sizes of the issue-stage replay queue.
 * Included by the package and by every module that sizes ports or state.
 */
`ifndef REPLAY_QUEUE_CONSTS_SVH
`define REPLAY_QUEUE_CONSTS_SVH

// Issue lanes recorded per cycle
`define RQ_INT_LANES 2
`define RQ_MEM_LANES 2

// Queue depth and pointer widths
`define RQ_ENTRIES 16
`define RQ_INDEX_BITS 4
`define RQ_COUNT_BITS 5

// Longest gap kept between two recorded groups
`define RQ_MAX_INTERVAL 7
`define RQ_INTERVAL_BITS 3

// Groups still in flight after the upper stages stall
`define RQ_MEM_LATENCY 3

// Miss status holding registers
`define RQ_MSHR_NUM 4
`define RQ_MSHR_BITS 2

// Active-list position width
`define RQ_AL_BITS 5

`endif

/* rtl/ReplayQueuePkg.sv */
/*
 * Types shared by the replay queue blocks.
 * Modules pull these in with a wildcard import in their header.
 */
`include "ReplayQueue_consts.svh"

package ReplayQueuePkg;

    typedef logic [`RQ_AL_BITS-1:0] ActiveListIndex;
    typedef logic [`RQ_MSHR_BITS-1:0] MshrIndex;

    // Order matters, readiness is a compare against PhaseWriteCache
    typedef enum logic [2:0] {
        PhaseFree        = 3'd0,
        PhaseMissRequest = 3'd1,
        PhaseMissWait    = 3'd2,
        PhaseWriteCache  = 3'd3,
        PhaseDone        = 3'd4
    } MshrPhase;

    typedef struct packed {
        ActiveListIndex activeListPtr;
        logic [15:0] tag;
    } IntOp;

    typedef struct packed {
        ActiveListIndex activeListPtr;
        logic isLoad;
        logic hasMshr;
        MshrIndex mshrId;
        logic [15:0] tag;
    } MemOp;

    // One recorded issue group plus its distance from the previous group
    typedef struct packed {
        logic [`RQ_INT_LANES-1:0] intValid;
        IntOp [`RQ_INT_LANES-1:0] intData;
        logic [`RQ_MEM_LANES-1:0] memValid;
        MemOp [`RQ_MEM_LANES-1:0] memData;
        logic [`RQ_INTERVAL_BITS-1:0] replayInterval;
    } QueueEntry;

endpackage

/* rtl/ReplayQueueStorage.sv */
/*
 * Circular store of recorded issue groups.
 * Decides the push, stamps each group with its arrival gap and
 * presents the head entry combinationally to the pop side.
 */
`timescale 1ns/1ns
`include "ReplayQueue_consts.svh"

module ReplayQueueStorage
    import ReplayQueuePkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic [`RQ_INT_LANES-1:0] intRecordValid,
    input  IntOp [`RQ_INT_LANES-1:0] intRecordData,
    input  logic [`RQ_MEM_LANES-1:0] memRecordValid,
    input  MemOp [`RQ_MEM_LANES-1:0] memRecordData,
    input  logic pop,
    output QueueEntry headEntry,
    output logic empty,
    output logic [`RQ_COUNT_BITS-1:0] count
);

    QueueEntry entries [`RQ_ENTRIES];
    QueueEntry recordEntry;

    logic [`RQ_INDEX_BITS-1:0] headPtr;
    logic [`RQ_INDEX_BITS-1:0] tailPtr;
    logic [`RQ_COUNT_BITS-1:0] validCount;
    logic [`RQ_INTERVAL_BITS-1:0] arrivalInterval;

    logic full;
    logic push;
    logic recordValid;
    logic headValid;

    assign recordValid = (|intRecordValid) || (|memRecordValid);
    assign headValid = (|headEntry.intValid) || (|headEntry.memValid);

    assign full = (count == `RQ_ENTRIES);
    assign empty = (count == '0);

    // Empty groups are kept only while a valid op waits, so gaps survive
    assign push = !full && (recordValid || validCount != '0);

    always_comb begin
        recordEntry.intValid = intRecordValid;
        recordEntry.intData = intRecordData;
        recordEntry.memValid = memRecordValid;
        recordEntry.memData = memRecordData;
        recordEntry.replayInterval = arrivalInterval;
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[tailPtr] <= recordEntry;
        end
    end

    assign headEntry = entries[headPtr];

    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            validCount <= '0;
            arrivalInterval <= '0;
        end else begin
            headPtr <= headPtr + `RQ_INDEX_BITS'(pop);
            tailPtr <= tailPtr + `RQ_INDEX_BITS'(push);
            count <= count + `RQ_COUNT_BITS'(push) - `RQ_COUNT_BITS'(pop);
            validCount <= validCount + `RQ_COUNT_BITS'(push && recordValid)
                - `RQ_COUNT_BITS'(pop && headValid);
            // Cycles since the last push, saturating
            if (push) begin
                arrivalInterval <= '0;
            end else if (arrivalInterval < `RQ_MAX_INTERVAL) begin
                arrivalInterval <= arrivalInterval + 1'b1;
            end
        end
    end

    // Count stays within the depth, so no push lands on a full queue
    assert property (@(posedge clock) disable iff (reset)
        count <= `RQ_ENTRIES);

endmodule

/* rtl/FlushRangeTracker.sv */
/*
 * Flush detection for the lanes of the head entry.
 * Holds the latest recovery range until every entry queued at that
 * time has replayed, and checks it together with the live range.
 */
`timescale 1ns/1ns
`include "ReplayQueue_consts.svh"

module FlushRangeTracker
    import ReplayQueuePkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic toRecovery,
    input  ActiveListIndex flushHead,
    input  ActiveListIndex flushTail,
    input  logic flushAll,
    input  logic [`RQ_COUNT_BITS-1:0] count,
    input  logic replay,
    input  QueueEntry headEntry,
    output logic [`RQ_INT_LANES-1:0] intFlushed,
    output logic [`RQ_MEM_LANES-1:0] memFlushed,
    output logic flushedOpExist
);

    ActiveListIndex rangeHead;
    ActiveListIndex rangeTail;
    logic rangeAll;
    logic [`RQ_COUNT_BITS-1:0] flushEntryCount;

    // Range runs from head up to, not including, tail and may wrap
    function automatic logic inFlushRange(input logic active, input ActiveListIndex head,
                                          input ActiveListIndex tail, input logic all,
                                          input ActiveListIndex ptr);
        logic covered;
        if (head <= tail) begin
            covered = (ptr >= head) && (ptr < tail);
        end else begin
            covered = (ptr >= head) || (ptr < tail);
        end
        return active && (all || covered);
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            flushEntryCount <= '0;
        end else if (toRecovery) begin
            flushEntryCount <= count;
        end else if (flushEntryCount != '0 && replay) begin
            flushEntryCount <= flushEntryCount - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (toRecovery) begin
            rangeHead <= flushHead;
            rangeTail <= flushTail;
            rangeAll <= flushAll;
        end
    end

    assign flushedOpExist = (flushEntryCount != '0);

    // Live range covers the cycle before the stored range takes effect
    always_comb begin
        for (int i = 0; i < `RQ_INT_LANES; i++) begin
            intFlushed[i] =
                inFlushRange(toRecovery, flushHead, flushTail, flushAll,
                             headEntry.intData[i].activeListPtr) ||
                inFlushRange(flushedOpExist, rangeHead, rangeTail, rangeAll,
                             headEntry.intData[i].activeListPtr);
        end
        for (int i = 0; i < `RQ_MEM_LANES; i++) begin
            memFlushed[i] =
                inFlushRange(toRecovery, flushHead, flushTail, flushAll,
                             headEntry.memData[i].activeListPtr) ||
                inFlushRange(flushedOpExist, rangeHead, rangeTail, rangeAll,
                             headEntry.memData[i].activeListPtr);
        end
    end

endmodule

/* rtl/ReplayPopControl.sv */
/*
 * Replay side of the queue.
 * Pops the head once its recorded gap has passed and no load in it
 * waits on an MSHR, registers the replayed group and drives the stall.
 */
`timescale 1ns/1ns
`include "ReplayQueue_consts.svh"

module ReplayPopControl
    import ReplayQueuePkg::*;
(
    input  logic clock,
    input  logic reset,
    input  QueueEntry headEntry,
    input  logic empty,
    input  logic [`RQ_COUNT_BITS-1:0] count,
    input  logic [`RQ_INT_LANES-1:0] intFlushed,
    input  logic [`RQ_MEM_LANES-1:0] memFlushed,
    input  logic [`RQ_MSHR_NUM-1:0] mshrValid,
    input  MshrPhase [`RQ_MSHR_NUM-1:0] mshrPhase,
    output logic pop,
    output logic replay,
    output logic [`RQ_INT_LANES-1:0] intReplayValid,
    output IntOp [`RQ_INT_LANES-1:0] intReplayData,
    output logic [`RQ_MEM_LANES-1:0] memReplayValid,
    output MemOp [`RQ_MEM_LANES-1:0] memReplayData,
    output logic stallUpper
);

    logic [`RQ_INTERVAL_BITS-1:0] sincePop;
    logic [`RQ_MEM_LANES-1:0] loadBlocked;
    logic headValid;
    logic intervalMet;
    logic almostFull;

    assign headValid = (|headEntry.intValid) || (|headEntry.memValid);
    assign intervalMet = (sincePop >= headEntry.replayInterval);

    // Flushed loads never wait, their MSHR may be gone already
    always_comb begin
        for (int i = 0; i < `RQ_MEM_LANES; i++) begin
            loadBlocked[i] = headEntry.memValid[i] && !memFlushed[i] &&
                headEntry.memData[i].isLoad && headEntry.memData[i].hasMshr &&
                mshrValid[headEntry.memData[i].mshrId] &&
                (mshrPhase[headEntry.memData[i].mshrId] < PhaseWriteCache);
        end
    end

    assign pop = !empty && intervalMet && !(|loadBlocked);

    always_ff @(posedge clock) begin
        if (reset) begin
            sincePop <= '0;
        end else if (pop) begin
            sincePop <= '0;
        end else if (sincePop < `RQ_MAX_INTERVAL) begin
            sincePop <= sincePop + 1'b1;
        end
    end

    // Registered replay group
    always_ff @(posedge clock) begin
        if (reset) begin
            replay <= 1'b0;
            intReplayValid <= '0;
            memReplayValid <= '0;
        end else begin
            replay <= pop && headValid;
            intReplayValid <= {`RQ_INT_LANES{pop}} & headEntry.intValid & ~intFlushed;
            memReplayValid <= {`RQ_MEM_LANES{pop}} & headEntry.memValid & ~memFlushed;
        end
    end

    always_ff @(posedge clock) begin
        intReplayData <= headEntry.intData;
        memReplayData <= headEntry.memData;
    end

    // Leave room for the groups already in flight behind the stall
    assign almostFull = (count >= (`RQ_ENTRIES - `RQ_MEM_LATENCY));
    assign stallUpper = replay || almostFull;

    // Never pops while the store holds no entries
    assert property (@(posedge clock) disable iff (reset)
        pop |-> count != '0);

endmodule

/* rtl/ReplayQueue.sv */
/*
 * Issue-stage replay queue, top level.
 * Connects the entry store, the flush range tracker and the pop control.
 */
`timescale 1ns/1ns
`include "ReplayQueue_consts.svh"

module ReplayQueue
    import ReplayQueuePkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic [`RQ_INT_LANES-1:0] intRecordValid,
    input  IntOp [`RQ_INT_LANES-1:0] intRecordData,
    input  logic [`RQ_MEM_LANES-1:0] memRecordValid,
    input  MemOp [`RQ_MEM_LANES-1:0] memRecordData,
    input  logic [`RQ_MSHR_NUM-1:0] mshrValid,
    input  MshrPhase [`RQ_MSHR_NUM-1:0] mshrPhase,
    input  logic toRecovery,
    input  ActiveListIndex flushHead,
    input  ActiveListIndex flushTail,
    input  logic flushAll,
    output logic [`RQ_INT_LANES-1:0] intReplayValid,
    output IntOp [`RQ_INT_LANES-1:0] intReplayData,
    output logic [`RQ_MEM_LANES-1:0] memReplayValid,
    output MemOp [`RQ_MEM_LANES-1:0] memReplayData,
    output logic replay,
    output logic stallUpper,
    output logic flushedOpExist
);

    QueueEntry headEntry;
    logic empty;
    logic [`RQ_COUNT_BITS-1:0] count;
    logic pop;
    logic [`RQ_INT_LANES-1:0] intFlushed;
    logic [`RQ_MEM_LANES-1:0] memFlushed;

    ReplayQueueStorage storage (
        .clock, .reset, .intRecordValid, .intRecordData, .memRecordValid,
        .memRecordData, .pop, .headEntry, .empty, .count
    );

    FlushRangeTracker flushTracker (
        .clock, .reset, .toRecovery, .flushHead, .flushTail, .flushAll, .count,
        .replay, .headEntry, .intFlushed, .memFlushed, .flushedOpExist
    );

    ReplayPopControl popControl (
        .clock, .reset, .headEntry, .empty, .count, .intFlushed, .memFlushed,
        .mshrValid, .mshrPhase, .pop, .replay, .intReplayValid, .intReplayData,
        .memReplayValid, .memReplayData, .stallUpper
    );

endmodule

/* testbench/ReplayQueueTb.sv */
/*
 * Directed testbench for the issue-stage replay queue.
 * Records issue groups, holds loads on MSHRs, flushes by active-list range
 * and checks the replayed groups, their spacing and the upper-stage stall.
 */
`timescale 1ns/1ns
`include "ReplayQueue_consts.svh"

module ReplayQueueTb
    import ReplayQueuePkg::*;
();

    typedef IntOp [`RQ_INT_LANES-1:0] IntGroup;
    typedef MemOp [`RQ_MEM_LANES-1:0] MemGroup;

    logic clock;
    logic reset;
    logic [`RQ_INT_LANES-1:0] intRecordValid;
    IntGroup intRecordData;
    logic [`RQ_MEM_LANES-1:0] memRecordValid;
    MemGroup memRecordData;
    logic [`RQ_MSHR_NUM-1:0] mshrValid;
    MshrPhase [`RQ_MSHR_NUM-1:0] mshrPhase;
    logic toRecovery;
    ActiveListIndex flushHead;
    ActiveListIndex flushTail;
    logic flushAll;
    logic [`RQ_INT_LANES-1:0] intReplayValid;
    IntGroup intReplayData;
    logic [`RQ_MEM_LANES-1:0] memReplayValid;
    MemGroup memReplayData;
    logic replay;
    logic stallUpper;
    logic flushedOpExist;

    logic [31:0] lfsrState = 32'hb403;
    int cycleCount = 0;
    int errorCount = 0;
    int testCount = 0;

    // Replayed groups and the cycle each one appeared in
    int capCycle [$];
    logic [`RQ_INT_LANES-1:0] capIntValid [$];
    IntGroup capIntData [$];
    logic [`RQ_MEM_LANES-1:0] capMemValid [$];
    MemGroup capMemData [$];

    ReplayQueue uut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < width; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic IntOp makeIntOp(input ActiveListIndex ptr);
        IntOp op;
        op.activeListPtr = ptr;
        op.tag = randomBits(16);
        return op;
    endfunction

    function automatic MemOp makeMemOp(input ActiveListIndex ptr, input logic isLoad,
                                       input logic hasMshr, input MshrIndex mshrId);
        MemOp op;
        op.activeListPtr = ptr;
        op.isLoad = isLoad;
        op.hasMshr = hasMshr;
        op.mshrId = mshrId;
        op.tag = randomBits(16);
        return op;
    endfunction

    // Distance from the range start, modulo the active-list size
    function automatic logic coveredByRange(input ActiveListIndex ptr,
                                            input ActiveListIndex head,
                                            input ActiveListIndex tail);
        ActiveListIndex offset;
        ActiveListIndex span;
        offset = ptr - head;
        span = tail - head;
        return offset < span;
    endfunction

    task automatic reportMismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
        errorCount++;
    endtask

    task automatic tick();
        @(posedge clock);
        #2;
        cycleCount++;
        if (replay) begin
            capCycle.push_back(cycleCount);
            capIntValid.push_back(intReplayValid);
            capIntData.push_back(intReplayData);
            capMemValid.push_back(memReplayValid);
            capMemData.push_back(memReplayData);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) tick();
    endtask

    task automatic clearCaptures();
        capCycle.delete();
        capIntValid.delete();
        capIntData.delete();
        capMemValid.delete();
        capMemData.delete();
    endtask

    task automatic driveGroup(input logic [`RQ_INT_LANES-1:0] intValid, input IntGroup ints,
                              input logic [`RQ_MEM_LANES-1:0] memValid, input MemGroup mems);
        intRecordValid = intValid;
        intRecordData = ints;
        memRecordValid = memValid;
        memRecordData = mems;
    endtask

    task automatic clearRecord();
        intRecordValid = '0;
        memRecordValid = '0;
    endtask

    task automatic waitReplays(input int wanted, input int limit, input string what);
        int waited;
        waited = 0;
        while (capCycle.size() < wanted && waited < limit) begin
            tick();
            waited++;
        end
        if (capCycle.size() < wanted) begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            errorCount++;
        end
    endtask

    task automatic checkGroup(input int index, input logic [`RQ_INT_LANES-1:0] intValid,
                              input IntGroup ints, input logic [`RQ_MEM_LANES-1:0] memValid,
                              input MemGroup mems);
        if (index >= capCycle.size()) begin
            $display("Replayed group %0d never arrived", index);
            errorCount++;
        end else begin
            if (capIntValid[index] !== intValid)
                reportMismatch("intReplayValid", intValid, capIntValid[index]);
            if (capIntData[index] !== ints)
                reportMismatch("intReplayData", ints, capIntData[index]);
            if (capMemValid[index] !== memValid)
                reportMismatch("memReplayValid", memValid, capMemValid[index]);
            if (capMemData[index] !== mems)
                reportMismatch("memReplayData", mems, capMemData[index]);
        end
    endtask

    task automatic endTest(input string name, input int startErrors);
        testCount++;
        $display("Test %0d %s: %0d errors", testCount, name, errorCount - startErrors);
    endtask

    task automatic resetStateTest();
        int startErrors;
        startErrors = errorCount;
        for (int i = 0; i < 2; i++) begin
            if (replay !== 1'b0) reportMismatch("replay", 0, replay);
            if (stallUpper !== 1'b0) reportMismatch("stallUpper", 0, stallUpper);
            if (flushedOpExist !== 1'b0) reportMismatch("flushedOpExist", 0, flushedOpExist);
            if (intReplayValid !== '0) reportMismatch("intReplayValid", 0, intReplayValid);
            if (memReplayValid !== '0) reportMismatch("memReplayValid", 0, memReplayValid);
            tick();
        end
        endTest("reset state", startErrors);
    endtask

    task automatic orderSpacingTest();
        IntGroup intA;
        IntGroup intB;
        MemGroup memA;
        MemGroup memB;
        int pushCycle;
        int startErrors;
        startErrors = errorCount;
        idle(8);
        clearCaptures();
        for (int lane = 0; lane < 2; lane++) begin
            intA[lane] = makeIntOp(ActiveListIndex'(1 + lane));
            memA[lane] = makeMemOp(ActiveListIndex'(3 + lane), 1'b0, 1'b0, 2'd0);
            intB[lane] = makeIntOp(ActiveListIndex'(5 + lane));
            memB[lane] = makeMemOp(ActiveListIndex'(7 + lane), 1'b0, 1'b0, 2'd0);
        end
        pushCycle = cycleCount;
        driveGroup(2'b11, intA, 2'b01, memA);
        tick();
        clearRecord();
        // Two empty cycles between the groups
        tick();
        tick();
        driveGroup(2'b01, intB, 2'b11, memB);
        tick();
        clearRecord();
        waitReplays(2, 12, "groups A and B");
        checkGroup(0, 2'b11, intA, 2'b01, memA);
        checkGroup(1, 2'b01, intB, 2'b11, memB);
        if (capCycle.size() >= 2) begin
            if (capCycle[0] - pushCycle != 2) begin
                $display("Group A replayed %0d cycles after its push, not 2",
                         capCycle[0] - pushCycle);
                errorCount++;
            end
            if (capCycle[1] - capCycle[0] != 3) begin
                $display("Group B replayed %0d cycles after group A, not 3",
                         capCycle[1] - capCycle[0]);
                errorCount++;
            end
        end
        endTest("order and spacing", startErrors);
    endtask

    task automatic mshrWaitTest();
        IntGroup ints;
        MemGroup mems;
        int startErrors;
        startErrors = errorCount;
        idle(8);
        clearCaptures();
        mshrValid[1] = 1'b1;
        mshrPhase[1] = PhaseMissWait;
        ints[0] = makeIntOp(5'd0);
        ints[1] = makeIntOp(5'd0);
        mems[0] = makeMemOp(5'd6, 1'b1, 1'b1, 2'd1);
        mems[1] = makeMemOp(5'd7, 1'b0, 1'b0, 2'd0);
        driveGroup(2'b00, ints, 2'b01, mems);
        tick();
        clearRecord();
        // Fewer than 13 entries stored during the hold, so no stall
        for (int i = 0; i < 10; i++) begin
            tick();
            if (stallUpper !== 1'b0) reportMismatch("stallUpper", 0, stallUpper);
        end
        if (capCycle.size() != 0) begin
            $display("Load replayed while its MSHR was still waiting");
            errorCount++;
        end
        mshrPhase[1] = PhaseWriteCache;
        waitReplays(1, 12, "the released load");
        checkGroup(0, 2'b00, ints, 2'b01, mems);
        mshrValid[1] = 1'b0;
        idle(20);
        endTest("MSHR wait", startErrors);
    endtask

    task automatic selectiveFlushTest();
        IntGroup sentInt [4];
        MemGroup sentMem [4];
        logic [`RQ_INT_LANES-1:0] expIntValid;
        logic [`RQ_MEM_LANES-1:0] expMemValid;
        ActiveListIndex rangeHead;
        ActiveListIndex rangeTail;
        int startErrors;
        startErrors = errorCount;
        rangeHead = 5'd10;
        rangeTail = 5'd14;
        idle(8);
        clearCaptures();
        mshrValid[2] = 1'b1;
        mshrPhase[2] = PhaseMissWait;
        // Held load first, then three groups spread over the active list
        for (int k = 0; k < 4; k++) begin
            for (int lane = 0; lane < 2; lane++) begin
                sentInt[k][lane] = makeIntOp(ActiveListIndex'(4 * k + 4 + lane));
            end
            if (k == 0) begin
                sentMem[k][0] = makeMemOp(5'd3, 1'b1, 1'b1, 2'd2);
            end else begin
                sentMem[k][0] = makeMemOp(ActiveListIndex'(4 * k + 6), 1'b0, 1'b0, 2'd0);
            end
            sentMem[k][1] = makeMemOp(ActiveListIndex'(4 * k + 7), 1'b0, 1'b0, 2'd0);
            driveGroup((k == 0) ? 2'b00 : 2'b11, sentInt[k], 2'b01, sentMem[k]);
            tick();
        end
        clearRecord();
        if (flushedOpExist !== 1'b0) reportMismatch("flushedOpExist", 0, flushedOpExist);
        toRecovery = 1'b1;
        flushHead = rangeHead;
        flushTail = rangeTail;
        tick();
        toRecovery = 1'b0;
        if (flushedOpExist !== 1'b1) reportMismatch("flushedOpExist", 1, flushedOpExist);
        mshrPhase[2] = PhaseDone;
        waitReplays(4, 20, "the flushed groups");
        if (flushedOpExist !== 1'b1) reportMismatch("flushedOpExist", 1, flushedOpExist);
        for (int k = 0; k < 4; k++) begin
            expIntValid = (k == 0) ? 2'b00 : 2'b11;
            expMemValid = 2'b01;
            for (int lane = 0; lane < 2; lane++) begin
                if (coveredByRange(sentInt[k][lane].activeListPtr, rangeHead, rangeTail))
                    expIntValid[lane] = 1'b0;
                if (coveredByRange(sentMem[k][lane].activeListPtr, rangeHead, rangeTail))
                    expMemValid[lane] = 1'b0;
            end
            checkGroup(k, expIntValid, sentInt[k], expMemValid, sentMem[k]);
        end
        tick();
        if (flushedOpExist !== 1'b0) reportMismatch("flushedOpExist", 0, flushedOpExist);
        mshrValid[2] = 1'b0;
        idle(20);
        endTest("selective flush", startErrors);
    endtask

    task automatic almostFullTest();
        IntGroup sentInt [14];
        MemGroup sentMem [14];
        int waited;
        int startErrors;
        startErrors = errorCount;
        idle(8);
        clearCaptures();
        mshrValid[3] = 1'b1;
        mshrPhase[3] = PhaseMissRequest;
        // At the start of step k the queue holds k entries
        for (int k = 0; k < 14; k++) begin
            if (stallUpper !== (k >= 13)) reportMismatch("stallUpper", k >= 13, stallUpper);
            sentInt[k][0] = makeIntOp(ActiveListIndex'(k + 20));
            sentInt[k][1] = makeIntOp(5'd0);
            sentMem[k][0] = makeMemOp(5'd19, k == 0, k == 0, 2'd3);
            sentMem[k][1] = makeMemOp(5'd0, 1'b0, 1'b0, 2'd0);
            driveGroup((k == 0) ? 2'b00 : 2'b01, sentInt[k], (k == 0) ? 2'b01 : 2'b00,
                       sentMem[k]);
            tick();
        end
        clearRecord();
        if (stallUpper !== 1'b1) reportMismatch("stallUpper", 1, stallUpper);
        mshrPhase[3] = PhaseWriteCache;
        waitReplays(14, 40, "the queue to drain");
        for (int k = 0; k < 14; k++) begin
            checkGroup(k, (k == 0) ? 2'b00 : 2'b01, sentInt[k], (k == 0) ? 2'b01 : 2'b00,
                       sentMem[k]);
        end
        waited = 0;
        while (stallUpper && waited < 40) begin
            tick();
            waited++;
        end
        if (stallUpper) begin
            $display("stallUpper stayed high after the queue drained");
            errorCount++;
        end
        mshrValid[3] = 1'b0;
        endTest("almost-full stall", startErrors);
    endtask

    initial begin
        reset = 1'b1;
        intRecordValid = '0;
        intRecordData = '0;
        memRecordValid = '0;
        memRecordData = '0;
        mshrValid = '0;
        for (int i = 0; i < `RQ_MSHR_NUM; i++) begin
            mshrPhase[i] = PhaseFree;
        end
        toRecovery = 1'b0;
        flushHead = '0;
        flushTail = '0;
        flushAll = 1'b0;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;

        resetStateTest();
        orderSpacingTest();
        mshrWaitTest();
        selectiveFlushTest();
        almostFullTest();

        $display("Tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/ReplayQueuePkg.sv
rtl/ReplayQueueStorage.sv
rtl/FlushRangeTracker.sv
rtl/ReplayPopControl.sv
rtl/ReplayQueue.sv
testbench/ReplayQueueTb.sv

/* Makefile */
# Verilator build and run of the replay queue testbench

VERILATOR ?= verilator
TOP ?= ReplayQueueTb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
